// File: design/credit_out_port.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_rx_cfg.svh"

module credit_out_port
    import udp_rx_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire rx_word_t rd_entry,
    input  wire logic     empty,
    input  wire logic     credit_return,
    output logic          rd_en,
    output logic          out_valid,
    output logic [31:0]   out_data,
    output logic          out_last,
    output logic [2:0]    out_nbytes
);

    localparam int          cw           = $clog2(`UDP_RX_CREDITS + 1);
    localparam logic [cw-1:0] init_credits = cw'(`UDP_RX_CREDITS);

    logic [cw-1:0] credits;      // words the sink can still take

    assign rd_en = !empty && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits   <= init_credits;
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
            case ({credit_return, rd_en})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: ;                       // return and send cancel out
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_data   <= rd_entry.data;
            out_last   <= rd_entry.last;
            out_nbytes <= rd_entry.nbytes;
        end
    end

endmodule

`default_nettype wire

// File: design/payload_packer.sv
`timescale 1ns/100ps
`default_nettype none

module payload_packer
    import udp_rx_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       pay_valid,
    input  wire logic [7:0] pay_byte,
    input  wire logic       pay_last,
    output logic            wr_en,
    output rx_word_t        wr_entry
);

    logic [1:0]  lane;          // 0 is the most significant byte
    logic [31:0] acc;           // bytes gathered so far
    logic [31:0] word_next;

    // lane 0 starts a fresh word so unused low lanes stay zero
    always_comb begin
        word_next = (lane == 2'd0) ? 32'd0 : acc;
        word_next[31 - 8*lane -: 8] = pay_byte;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane  <= 2'd0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= pay_valid && (lane == 2'd3 || pay_last);
            if (pay_valid) begin
                lane <= pay_last ? 2'd0 : lane + 2'd1;   // wraps after lane 3
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pay_valid) begin
            acc             <= word_next;
            wr_entry.data   <= word_next;
            wr_entry.last   <= pay_last;
            wr_entry.nbytes <= {1'b0, lane} + 3'd1;
        end
    end

endmodule

`default_nettype wire

// File: design/rx_word_fifo.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_rx_cfg.svh"

module rx_word_fifo
    import udp_rx_pkg::*;
(
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                wr_en,
    input  wire rx_word_t                            wr_entry,
    input  wire logic                                rd_en,
    output rx_word_t                                 rd_entry,
    output logic                                     empty,
    output logic [$clog2(`UDP_RX_FIFO_DEPTH):0]      free_count
);

    localparam int          depth      = `UDP_RX_FIFO_DEPTH;
    localparam int          aw         = $clog2(depth);
    localparam logic [aw:0] full_level = (aw + 1)'(depth);

    rx_word_t      mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;
    logic [aw:0]   count;        // occupancy
    logic          do_wr;
    logic          do_rd;

    assign do_wr      = wr_en && (count != full_level);
    assign do_rd      = rd_en && !empty;
    assign empty      = (count == '0);
    assign free_count = full_level - count;
    assign rd_entry   = mem[rd_ptr];             // head entry, no read latency

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;         // wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                       // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/udp_rx_cfg.svh
`ifndef UDP_RX_CFG_SVH
`define UDP_RX_CFG_SVH

// ******************************
// board identity
// ******************************
`define UDP_RX_BOARD_MAC  48'h02_00_00_00_00_01  // locally administered
`define UDP_RX_BOARD_IP   32'hc0_a8_01_0a        // 192.168.1.10

// ******************************
// buffering and flow control
// ******************************
`define UDP_RX_FIFO_DEPTH 16                     // word entries, power of two
`define UDP_RX_CREDITS    4                      // granted by the sink at reset

`endif

// File: design/udp_rx_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_rx_cfg.svh"

module udp_rx_ctrl
    import udp_rx_pkg::*;
(
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 gmii_rx_dv,
    input  wire logic [7:0]                           gmii_rxd,
    input  wire logic [$clog2(`UDP_RX_FIFO_DEPTH):0]  free_count,
    output logic                                      pay_valid,
    output logic [7:0]                                pay_byte,
    output logic                                      pay_last,
    output logic [15:0]                               drop_count
);

    localparam int          fw          = $clog2(`UDP_RX_FIFO_DEPTH) + 1;
    localparam logic [47:0] bcast_mac   = 48'hff_ff_ff_ff_ff_ff;
    localparam logic [15:0] eth_type_ip = 16'h0800;

    rx_state_t   state;
    logic [5:0]  cnt;              // byte index inside the current section
    logic [47:0] des_mac;
    logic [7:0]  eth_type_hi;
    logic [5:0]  ip_hlen;          // ip header length in bytes
    logic [23:0] des_ip_hi;        // first three bytes of the destination ip
    logic [15:0] udp_len;
    byte_cnt_t   pay_len;
    byte_cnt_t   pay_len_next;
    byte_cnt_t   pay_words;
    byte_cnt_t   data_cnt;
    logic        mac_ok;
    logic        type_ok;
    logic        ip_ok;
    logic        room_ok;
    logic        len_last;         // registered byte was the last by udp length
    logic        reject;

    assign mac_ok       = (des_mac == `UDP_RX_BOARD_MAC) || (des_mac == bcast_mac);
    assign type_ok      = ({eth_type_hi, gmii_rxd} == eth_type_ip);
    assign ip_ok        = ({des_ip_hi, gmii_rxd} == `UDP_RX_BOARD_IP);
    assign pay_len_next = udp_len - 16'd8;
    assign pay_words    = {2'b00, pay_len_next[15:2]} + {15'd0, |pay_len_next[1:0]};
    assign room_ok      = pay_words <= {{(16 - fw){1'b0}}, free_count};

    // dv falling right after a payload byte marks a truncated frame
    assign pay_last = pay_valid && (len_last || !gmii_rx_dv);

    // ******************************
    // frame walk
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            cnt       <= '0;
            data_cnt  <= '0;
            pay_valid <= 1'b0;
            len_last  <= 1'b0;
            reject    <= 1'b0;
        end else begin
            pay_valid <= 1'b0;
            len_last  <= 1'b0;
            reject    <= 1'b0;
            cnt       <= cnt + 6'd1;
            if (!gmii_rx_dv && state != st_idle) begin
                state  <= st_idle;
                reject <= state inside {st_eth_head, st_ip_head, st_udp_head};  // cut header
            end else begin
                case (state)
                    st_idle: begin
                        cnt <= 6'd1;
                        if (gmii_rx_dv) begin
                            state <= (gmii_rxd == 8'h55) ? st_preamble : st_rx_end;
                        end
                    end
                    st_preamble: begin
                        if (gmii_rxd == 8'hd5 && cnt == 6'd7) begin
                            state <= st_eth_head;
                            cnt   <= '0;
                        end else if (gmii_rxd != 8'h55 || cnt == 6'd7) begin
                            state <= st_rx_end;                  // bad framing, not counted
                        end
                    end
                    st_eth_head: begin
                        if (cnt == 6'd13) begin
                            cnt <= '0;
                            if (mac_ok && type_ok) begin
                                state <= st_ip_head;
                            end else begin
                                state  <= st_rx_end;
                                reject <= 1'b1;
                            end
                        end
                    end
                    st_ip_head: begin
                        if (cnt == 6'd19 && !ip_ok) begin
                            state  <= st_rx_end;
                            reject <= 1'b1;
                        end else if (cnt >= 6'd19 && cnt == ip_hlen - 6'd1) begin
                            state <= st_udp_head;                // options skipped
                            cnt   <= '0;
                        end
                    end
                    st_udp_head: begin
                        if (cnt == 6'd7) begin
                            cnt      <= '0;
                            data_cnt <= '0;
                            if (!room_ok) begin
                                state  <= st_rx_end;             // whole frame would not fit
                                reject <= 1'b1;
                            end else if (pay_len_next == '0) begin
                                state <= st_rx_end;
                            end else begin
                                state <= st_rx_data;
                            end
                        end
                    end
                    st_rx_data: begin
                        pay_valid <= 1'b1;
                        data_cnt  <= data_cnt + 16'd1;
                        if (data_cnt == pay_len - 16'd1) begin
                            len_last <= 1'b1;
                            state    <= st_rx_end;               // fcs bytes follow
                        end
                    end
                    default: ;                                   // rx_end waits for dv low
                endcase
            end
        end
    end

    // header fields, sampled by position
    always_ff @(posedge clk) begin
        pay_byte <= gmii_rxd;
        if (gmii_rx_dv) begin
            case (state)
                st_eth_head: begin
                    if (cnt < 6'd6) begin
                        des_mac <= {des_mac[39:0], gmii_rxd};
                    end
                    if (cnt == 6'd12) begin
                        eth_type_hi <= gmii_rxd;
                    end
                end
                st_ip_head: begin
                    if (cnt == 6'd0) begin
                        ip_hlen <= {gmii_rxd[3:0], 2'b00};       // ihl in words
                    end
                    if (cnt >= 6'd16 && cnt <= 6'd18) begin
                        des_ip_hi <= {des_ip_hi[15:0], gmii_rxd};
                    end
                end
                st_udp_head: begin
                    if (cnt == 6'd4) begin
                        udp_len[15:8] <= gmii_rxd;
                    end
                    if (cnt == 6'd5) begin
                        udp_len[7:0] <= gmii_rxd;
                    end
                    if (cnt == 6'd7) begin
                        pay_len <= pay_len_next;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (reject) begin
            drop_count <= drop_count + 16'd1;
        end
    end

endmodule

`default_nettype wire

// File: design/udp_rx_pkg.sv
`default_nettype none

package udp_rx_pkg;

    // parser states, named for waveform viewing
    typedef enum logic [2:0] {
        st_idle, st_preamble, st_eth_head, st_ip_head, st_udp_head, st_rx_data, st_rx_end
    } rx_state_t;

    typedef logic [15:0] byte_cnt_t;     // udp and payload byte counts

    typedef struct packed {
        logic [31:0] data;               // first byte in [31:24]
        logic        last;               // final word of the payload
        logic [2:0]  nbytes;             // 1 to 4 valid bytes
    } rx_word_t;

endpackage

`default_nettype wire

// File: design/udp_rx_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_rx_cfg.svh"

module udp_rx_top
    import udp_rx_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       gmii_rx_dv,
    input  wire logic [7:0] gmii_rxd,
    input  wire logic       credit_return,
    output logic            out_valid,
    output logic [31:0]     out_data,
    output logic            out_last,
    output logic [2:0]      out_nbytes,
    output logic [15:0]     drop_count
);

    // ******************************
    // internal nets
    // ******************************
    logic                                pay_valid;
    logic [7:0]                          pay_byte;
    logic                                pay_last;
    logic                                wr_en;
    rx_word_t                            wr_entry;
    logic                                rd_en;
    rx_word_t                            rd_entry;
    logic                                empty;
    logic [$clog2(`UDP_RX_FIFO_DEPTH):0] free_count;

    udp_rx_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gmii_rx_dv (gmii_rx_dv),
        .gmii_rxd   (gmii_rxd),
        .free_count (free_count),
        .pay_valid  (pay_valid),
        .pay_byte   (pay_byte),
        .pay_last   (pay_last),
        .drop_count (drop_count)
    );

    payload_packer packer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pay_valid (pay_valid),
        .pay_byte  (pay_byte),
        .pay_last  (pay_last),
        .wr_en     (wr_en),
        .wr_entry  (wr_entry)
    );

    rx_word_fifo fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_entry   (wr_entry),
        .rd_en      (rd_en),
        .rd_entry   (rd_entry),
        .empty      (empty),
        .free_count (free_count)
    );

    credit_out_port out_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_entry      (rd_entry),
        .empty         (empty),
        .credit_return (credit_return),
        .rd_en         (rd_en),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_last      (out_last),
        .out_nbytes    (out_nbytes)
    );

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/udp_rx_pkg.sv
design/udp_rx_ctrl.sv
design/payload_packer.sv
design/rx_word_fifo.sv
design/credit_out_port.sv
design/udp_rx_top.sv
testbench/udp_rx_tb.sv

// File: testbench/udp_rx_cases.txt
# num mac(own/bcast/other) ip(own/other) pay_len ihl_words cut delay
# cut 1 lets dv fall halfway through the payload; delay 0 holds credits, frames back to back
1  own   own   23 5 0 2
2  bcast own   16 5 0 1
3  other own   12 5 0 2
4  own   other 12 5 0 2
5  own   own   30 7 0 3
6  own   own   48 5 0 40
7  own   own   27 5 1 2
8  bcast own   5  6 0 1
9  own   own   40 5 0 0
10 own   own   36 5 0 0
11 own   own   8  5 0 0
12 own   own   4  5 0 0
13 own   own   9  5 0 5
14 own   own   64 5 0 1
15 own   own   68 5 0 1
16 own   own   1  5 0 3
17 bcast other 20 5 0 2
18 own   own   14 8 1 1

// File: testbench/udp_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "udp_rx_cfg.svh"

module udp_rx_tb;

    localparam int          fifo_depth  = `UDP_RX_FIFO_DEPTH;
    localparam int          max_credits = `UDP_RX_CREDITS;
    localparam int          gap_cycles  = 12;
    localparam int          wait_limit  = 5000;
    localparam logic [47:0] other_mac   = 48'h02_00_00_00_00_99;
    localparam logic [47:0] src_mac     = 48'h02_00_00_00_00_aa;
    localparam logic [31:0] other_ip    = 32'hc0_a8_01_63;
    localparam logic [31:0] src_ip      = 32'hc0_a8_01_01;

    logic        clk;
    logic        rst_n;
    logic        gmii_rx_dv;
    logic [7:0]  gmii_rxd;
    logic        credit_return;
    logic        out_valid;
    logic [31:0] out_data;
    logic        out_last;
    logic [2:0]  out_nbytes;
    logic [15:0] drop_count;

    integer      seed;
    int          errors;
    int          ncases;
    int          cyc;
    int          sent;              // words seen on the output
    int          returned;          // credits handed back
    int          written;           // words expected into the fifo
    int          received;
    int          exp_drops;
    int          ret_delay;
    logic        hold;              // sink keeps its credits
    logic        timed_out;         // output stalled, stop waiting
    logic [7:0]  frame [$];
    logic [7:0]  payload [$];
    logic [31:0] exp_data [$];
    logic        exp_last [$];
    logic [2:0]  exp_nbytes [$];
    int          ret_time [$];      // cycle each credit goes back
    int          pend_num [$];
    int          pend_words [$];

    udp_rx_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .gmii_rx_dv    (gmii_rx_dv),
        .gmii_rxd      (gmii_rxd),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_last      (out_last),
        .out_nbytes    (out_nbytes),
        .drop_count    (drop_count)
    );

    always #2 clk = ~clk;

    // ******************************
    // sink with credit return
    // ******************************
    always @(posedge clk) begin
        cyc = cyc + 1;
        if (rst_n && out_valid) begin
            sent     = sent + 1;
            received = received + 1;
            ret_time.push_back(cyc + ret_delay);
            check_word();
        end
        assert (sent - returned <= max_credits) else begin
            $display("** Error at %0t: %0d words outstanding, limit %0d",
                     $time, sent - returned, max_credits);
            errors = errors + 1;
        end
        #1;
        if (!hold && ret_time.size() != 0 && ret_time[0] <= cyc) begin
            void'(ret_time.pop_front());
            credit_return = 1'b1;
            returned      = returned + 1;
        end else begin
            credit_return = 1'b0;
        end
    end

    task automatic check_word();
        logic        has_exp;
        logic [31:0] d;
        logic        l;
        logic [2:0]  n;
        has_exp = (exp_data.size() != 0);
        assert (has_exp) else begin
            $display("** Error at %0t: word %h arrived with none expected", $time, out_data);
            errors = errors + 1;
        end
        if (has_exp) begin
            d = exp_data.pop_front();
            l = exp_last.pop_front();
            n = exp_nbytes.pop_front();
            assert (out_data == d && out_last == l && out_nbytes == n) else begin
                $display({"** Error at %0t: got %h last %b nbytes %0d,",
                          " expected %h last %b nbytes %0d"},
                         $time, out_data, out_last, out_nbytes, d, l, n);
                errors = errors + 1;
            end
        end
    endtask

    // ******************************
    // frame building
    // ******************************
    task automatic push_bytes(input logic [47:0] value, input int nbytes);
        int i;
        for (i = nbytes - 1; i >= 0; i--) begin
            frame.push_back(value[8*i +: 8]);   // network order
        end
    endtask

    task automatic build_frame(input logic [63:0] mac_sel, input logic [63:0] ip_sel,
                               input int len, input int ihl, input int nsend, input int cut);
        logic [47:0] dst_mac;
        logic [31:0] dst_ip;
        logic [31:0] r;
        int          i;
        frame.delete();
        payload.delete();
        if (mac_sel == "own") begin
            dst_mac = `UDP_RX_BOARD_MAC;
        end else if (mac_sel == "bcast") begin
            dst_mac = 48'hff_ff_ff_ff_ff_ff;
        end else begin
            dst_mac = other_mac;
        end
        dst_ip = (ip_sel == "own") ? `UDP_RX_BOARD_IP : other_ip;
        repeat (7) frame.push_back(8'h55);
        frame.push_back(8'hd5);
        push_bytes(dst_mac, 6);
        push_bytes(src_mac, 6);
        push_bytes(48'h0800, 2);                   // ethertype ipv4
        frame.push_back({4'h4, 4'(ihl)});
        frame.push_back(8'h00);
        push_bytes(48'(ihl * 4 + 8 + len), 2);     // ip total length
        push_bytes(48'h0000_4000, 4);              // id, df
        push_bytes(48'h4011, 2);                   // ttl, udp
        push_bytes(48'h0, 2);
        push_bytes(48'(src_ip), 4);
        push_bytes(48'(dst_ip), 4);
        repeat ((ihl - 5) * 4) frame.push_back(8'h00);   // options
        push_bytes(48'h1234_04d2, 4);              // ports
        push_bytes(48'(len + 8), 2);
        push_bytes(48'h0, 2);
        for (i = 0; i < len; i++) begin
            r = $random(seed);
            payload.push_back(r[7:0]);
        end
        for (i = 0; i < nsend; i++) begin
            frame.push_back(payload[i]);
        end
        if (cut == 0) begin
            for (i = 0; i < 4; i++) begin
                r = $random(seed);
                frame.push_back(r[7:0]);           // fcs, ignored by the dut
            end
        end
    endtask

    // msb-first packing, last flag on the final word only
    task automatic expect_words(input int n);
        int          i;
        int          k;
        int          nw;
        logic [31:0] d;
        nw = (n + 3) / 4;
        for (i = 0; i < nw; i++) begin
            d = 32'd0;
            for (k = 0; k < 4; k++) begin
                if (4 * i + k < n) begin
                    d[31 - 8*k -: 8] = payload[4 * i + k];
                end
            end
            exp_data.push_back(d);
            exp_last.push_back(i == nw - 1);
            exp_nbytes.push_back((i == nw - 1 && n % 4 != 0) ? 3'(n % 4) : 3'd4);
        end
        written = written + nw;
    endtask

    task automatic send_frame();
        int i;
        for (i = 0; i < frame.size(); i++) begin
            @(posedge clk);
            #1;
            gmii_rx_dv = 1'b1;
            gmii_rxd   = frame[i];
        end
        @(posedge clk);
        #1;
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
        repeat (gap_cycles) @(posedge clk);
    endtask

    // ******************************
    // run control
    // ******************************
    task automatic finish_run();
        $display("cases %0d, words %0d, drops %0d, errors %0d",
                 ncases, received, drop_count, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (!timed_out && (received < written || ret_time.size() != 0)) begin
            if (n == wait_limit) begin
                $display("timeout: only %0d of %0d words arrived, %0d credits still held",
                         received, written, ret_time.size());
                errors    = errors + 1;
                timed_out = 1'b1;
            end else begin
                @(posedge clk);
                n = n + 1;
            end
        end
        if (!timed_out) begin
            repeat (4) @(posedge clk);
        end
    endtask

    task automatic print_case(input int num, input int words);
        $display("case %0d done: %0d words, drop_count %0d, errors %0d",
                 num, words, drop_count, errors);
    endtask

    task automatic print_pending();
        while (pend_num.size() != 0) begin
            print_case(pend_num.pop_front(), pend_words.pop_front());
        end
    endtask

    task automatic run_case(input int num, input logic [63:0] mac_sel, input logic [63:0] ip_sel,
                            input int len, input int ihl, input int cut, input int delay);
        int   nsend;
        int   words;
        int   free_now;
        logic accept;
        ncases = ncases + 1;
        hold   = (delay == 0);
        if (delay != 0) begin
            ret_delay = delay;
            drain();                               // empty fifo before a free-running case
            print_pending();
        end
        nsend = (cut != 0) ? len / 2 : len;
        build_frame(mac_sel, ip_sel, len, ihl, nsend, cut);
        free_now = fifo_depth - (written - received);
        accept   = (mac_sel == "own" || mac_sel == "bcast") && ip_sel == "own" &&
                   (len + 3) / 4 <= free_now;
        words    = accept ? (nsend + 3) / 4 : 0;
        if (accept) begin
            expect_words(nsend);
        end else begin
            exp_drops = exp_drops + 1;
        end
        send_frame();
        assert (drop_count == exp_drops) else begin
            $display("** Error at %0t: case %0d drop_count %0d, expected %0d",
                     $time, num, drop_count, exp_drops);
            errors = errors + 1;
        end
        if (delay != 0) begin
            drain();
            print_case(num, words);
        end else begin
            pend_num.push_back(num);
            pend_words.push_back(words);
        end
    endtask

    initial begin
        integer           fd;
        integer           nf;
        logic [8*128-1:0] line;
        logic [63:0]      mac_sel;
        logic [63:0]      ip_sel;
        int               num;
        int               len;
        int               ihl;
        int               cut;
        int               delay;
        clk           = 1'b0;
        rst_n         = 1'b0;
        gmii_rx_dv    = 1'b0;
        gmii_rxd      = 8'h00;
        credit_return = 1'b0;
        hold          = 1'b0;
        timed_out     = 1'b0;
        seed          = 32'h87f02a55;
        errors        = 0;
        ncases        = 0;
        cyc           = 0;
        sent          = 0;
        returned      = 0;
        written       = 0;
        received      = 0;
        exp_drops     = 0;
        ret_delay     = 1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fd = $fopen("testbench/udp_rx_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/udp_rx_cases.txt");
            errors = errors + 1;
            finish_run();
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = '0;
                nf   = $fgets(line, fd);
                if (nf != 0 && $sscanf(line, "%d %s %s %d %d %d %d",
                                       num, mac_sel, ip_sel, len, ihl, cut, delay) == 7) begin
                    run_case(num, mac_sel, ip_sel, len, ihl, cut, delay);
                end
            end
            $fclose(fd);
            hold = 1'b0;
            drain();
            print_pending();
            finish_run();
        end
    end

endmodule

`default_nettype wire
